//--- src/fb_pkg.sv
package fb_pkg;

	////////////////////
	// Buffer pool

	// Memory address and frame timestamp widths
	localparam int FB_ADDR_W = 32;
	localparam int FB_TS_W   = 64;

	// Writer needs one free buffer beyond what readers and last frame hold
	localparam int FB_READER_NUM = 2;
	localparam int FB_BUF_NUM    = FB_READER_NUM + 2;
	localparam int FB_IDX_W      = $clog2(FB_BUF_NUM);

	////////////////////
	// Types

	// Byte address in memory
	typedef logic [FB_ADDR_W-1:0] fb_addr_t;

	// Buffer number
	typedef logic [FB_IDX_W-1:0] fb_idx_t;

	// System time at frame completion
	typedef logic [FB_TS_W-1:0] fb_ts_t;

	// One bit per buffer, one-hot when naming a single holder
	typedef logic [FB_BUF_NUM-1:0] fb_bmp_t;

endpackage

//--- src/video_pkg.sv
package video_pkg;

	////////////////////
	// Frame geometry

	localparam int FRAME_WIDTH     = 16;
	localparam int FRAME_HEIGHT    = 8;
	localparam int BYTES_PER_PIXEL = 4;

	// Line pitch in bytes, wider than one line of pixels
	localparam int LINE_STRIDE = 128;

	localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;

	////////////////////
	// Counter widths for the address walk

	localparam int PIX_CNT_W  = $clog2(FRAME_WIDTH);
	localparam int LINE_CNT_W = $clog2(FRAME_HEIGHT);

endpackage

//--- src/buffer_addr_table.sv
module buffer_addr_table import fb_pkg::*; (
	input  logic     clk,
	input  logic     resetn,

	// Configuration write port
	input  logic     cfg_we,
	input  fb_idx_t  cfg_idx,
	input  fb_addr_t cfg_addr,

	// Base address of every buffer
	output fb_addr_t buf_addr [FB_BUF_NUM]
);

	////////////////////
	// Table storage

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < FB_BUF_NUM; i++) begin
				buf_addr[i] <= '0;
			end
		end else if (cfg_we) begin
			buf_addr[cfg_idx] <= cfg_addr;
		end
	end

	////////////////////
	// Checks

	// Write must target a known entry
	a_cfg_idx_known: assert property (
		@(posedge clk) disable iff (!resetn)
		cfg_we |-> !$isunknown(cfg_idx)
	);

endmodule

//--- src/mutex_buffer.sv
module mutex_buffer import fb_pkg::*; (
	input  logic     clk,
	input  logic     resetn,

	input  fb_addr_t buf_addr [FB_BUF_NUM],
	input  fb_ts_t   sys_ts,

	// Writer
	input  logic     w_sof,
	output fb_addr_t w_addr,
	output fb_idx_t  w_idx,

	// Reader 0
	input  logic     r0_sof,
	output fb_addr_t r0_addr,
	output fb_idx_t  r0_idx,
	output fb_ts_t   r0_ts,

	// Reader 1
	input  logic     r1_sof,
	output fb_addr_t r1_addr,
	output fb_idx_t  r1_idx,
	output fb_ts_t   r1_ts
);

	// Writer holding
	fb_bmp_t  w_bmp;

	// Last completed frame
	fb_addr_t last_addr;
	fb_bmp_t  last_bmp;
	fb_idx_t  last_idx;
	fb_ts_t   last_ts;

	// Reader holdings, one slot per reader
	logic     rd_sof  [FB_READER_NUM];
	fb_addr_t rd_addr [FB_READER_NUM];
	fb_bmp_t  rd_bmp  [FB_READER_NUM];
	fb_idx_t  rd_idx  [FB_READER_NUM];
	fb_ts_t   rd_ts   [FB_READER_NUM];

	// Free buffer search
	fb_bmp_t  busy_bmp;
	fb_idx_t  free_idx;

	////////////////////
	// Free buffer search

	always_comb begin
		busy_bmp = w_bmp;
		for (int r = 0; r < FB_READER_NUM; r++) begin
			busy_bmp = busy_bmp | rd_bmp[r];
		end
	end

	// Lowest clear bit wins, scanned from the top down
	always_comb begin
		free_idx = fb_idx_t'(1);
		for (int i = FB_BUF_NUM - 1; i >= 0; i--) begin
			if (!busy_bmp[i]) begin
				free_idx = fb_idx_t'(i);
			end
		end
	end

	////////////////////
	// Writer

	always_ff @(posedge clk) begin
		if (!resetn) begin
			w_addr <= '0;
			w_bmp  <= fb_bmp_t'(1) << 1;
			w_idx  <= fb_idx_t'(1);
		end else if (w_sof) begin
			w_addr <= buf_addr[free_idx];
			w_bmp  <= fb_bmp_t'(1) << free_idx;
			w_idx  <= free_idx;
		end
	end

	// Frame the writer leaves becomes the one readers get
	always_ff @(posedge clk) begin
		if (!resetn) begin
			last_addr <= '0;
			last_bmp  <= fb_bmp_t'(1);
			last_idx  <= '0;
			last_ts   <= '0;
		end else if (w_sof) begin
			last_addr <= w_addr;
			last_bmp  <= w_bmp;
			last_idx  <= w_idx;
			last_ts   <= sys_ts;
		end
	end

	////////////////////
	// Readers

	assign rd_sof[0] = r0_sof;
	assign rd_sof[1] = r1_sof;

	for (genvar r = 0; r < FB_READER_NUM; r++) begin : g_reader
		always_ff @(posedge clk) begin
			if (!resetn) begin
				rd_addr[r] <= '0;
				rd_bmp[r]  <= fb_bmp_t'(1);
				rd_idx[r]  <= '0;
				rd_ts[r]   <= '0;
			end else if (rd_sof[r]) begin
				// Writer finishing right now hands over its frame directly
				if (w_sof) begin
					rd_addr[r] <= w_addr;
					rd_bmp[r]  <= w_bmp;
					rd_idx[r]  <= w_idx;
					rd_ts[r]   <= sys_ts;
				end else begin
					rd_addr[r] <= last_addr;
					rd_bmp[r]  <= last_bmp;
					rd_idx[r]  <= last_idx;
					rd_ts[r]   <= last_ts;
				end
			end
		end
	end

	assign r0_addr = rd_addr[0];
	assign r0_idx  = rd_idx[0];
	assign r0_ts   = rd_ts[0];
	assign r1_addr = rd_addr[1];
	assign r1_idx  = rd_idx[1];
	assign r1_ts   = rd_ts[1];

	////////////////////
	// Checks

	// Writer never shares a buffer with a reader
	a_w_exclusive: assert property (
		@(posedge clk) disable iff (!resetn)
		(w_idx != rd_idx[0]) && (w_idx != rd_idx[1])
	);

	a_bmp_onehot: assert property (
		@(posedge clk) disable iff (!resetn)
		$onehot(w_bmp) && $onehot(last_bmp) && $onehot(rd_bmp[0]) && $onehot(rd_bmp[1])
	);

	a_w_bmp_idx: assert property (
		@(posedge clk) disable iff (!resetn)
		w_bmp == (fb_bmp_t'(1) << w_idx)
	);

endmodule

//--- src/frame_addr_gen.sv
module frame_addr_gen
	import fb_pkg::*;
	import video_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,

	input  logic     sof,
	input  logic     beat,
	input  fb_addr_t base,

	output fb_addr_t addr,
	output logic     eol,
	output logic     eof
);

	logic                  sof_d;
	logic                  active;
	fb_addr_t              base_q;
	logic [PIX_CNT_W-1:0]  pix_cnt;
	logic [LINE_CNT_W-1:0] line_cnt;
	logic                  last_pix;
	logic                  last_line;

	assign last_pix  = (pix_cnt == PIX_CNT_W'(FRAME_WIDTH - 1));
	assign last_line = (line_cnt == LINE_CNT_W'(FRAME_HEIGHT - 1));

	////////////////////
	// Walk control

	// Arbiter output is valid one cycle after sof, so capture then
	always_ff @(posedge clk) begin
		if (!resetn) begin
			sof_d    <= 1'b0;
			active   <= 1'b0;
			base_q   <= '0;
			pix_cnt  <= '0;
			line_cnt <= '0;
			eol      <= 1'b0;
			eof      <= 1'b0;
		end else begin
			sof_d <= sof;
			eol   <= 1'b0;
			eof   <= 1'b0;
			if (sof_d) begin
				base_q   <= base;
				pix_cnt  <= '0;
				line_cnt <= '0;
				active   <= !sof;
			end else if (sof) begin
				active <= 1'b0;
			end else if (active && beat) begin
				if (last_pix) begin
					pix_cnt <= '0;
					eol     <= 1'b1;
					if (last_line) begin
						// Frame done, wait for the next sof
						line_cnt <= '0;
						eof      <= 1'b1;
						active   <= 1'b0;
					end else begin
						line_cnt <= line_cnt + 1'b1;
					end
				end else begin
					pix_cnt <= pix_cnt + 1'b1;
				end
			end
		end
	end

	////////////////////
	// Address

	assign addr = base_q
		+ fb_addr_t'(line_cnt) * fb_addr_t'(LINE_STRIDE)
		+ fb_addr_t'(pix_cnt) * fb_addr_t'(BYTES_PER_PIXEL);

	// Line and frame ends only come from beats taken while walking
	a_no_idle_pulse: assert property (
		@(posedge clk) disable iff (!resetn)
		(eol || eof) |-> $past(active)
	);

endmodule

//--- src/frame_buffer_ctl.sv
module frame_buffer_ctl import fb_pkg::*; (
	input  logic     clk,
	input  logic     resetn,

	// Base address configuration
	input  logic     cfg_we,
	input  fb_idx_t  cfg_idx,
	input  fb_addr_t cfg_addr,

	input  fb_ts_t   sys_ts,

	// Writer
	input  logic     w_sof,
	input  logic     w_beat,
	output fb_addr_t w_addr,
	output fb_idx_t  w_idx,
	output logic     w_eol,
	output logic     w_eof,

	// Reader 0
	input  logic     r0_sof,
	input  logic     r0_beat,
	output fb_addr_t r0_addr,
	output fb_idx_t  r0_idx,
	output fb_ts_t   r0_ts,
	output logic     r0_eol,
	output logic     r0_eof,

	// Reader 1
	input  logic     r1_sof,
	input  logic     r1_beat,
	output fb_addr_t r1_addr,
	output fb_idx_t  r1_idx,
	output fb_ts_t   r1_ts,
	output logic     r1_eol,
	output logic     r1_eof
);

	fb_addr_t buf_addr [FB_BUF_NUM];

	// Buffer base per port, from the arbiter
	fb_addr_t w_base;
	fb_addr_t r0_base;
	fb_addr_t r1_base;

	////////////////////
	// Buffer table and arbiter

	buffer_addr_table u_table (
		.clk      (clk),
		.resetn   (resetn),
		.cfg_we   (cfg_we),
		.cfg_idx  (cfg_idx),
		.cfg_addr (cfg_addr),
		.buf_addr (buf_addr)
	);

	mutex_buffer u_mutex (
		.clk      (clk),
		.resetn   (resetn),
		.buf_addr (buf_addr),
		.sys_ts   (sys_ts),
		.w_sof    (w_sof),
		.w_addr   (w_base),
		.w_idx    (w_idx),
		.r0_sof   (r0_sof),
		.r0_addr  (r0_base),
		.r0_idx   (r0_idx),
		.r0_ts    (r0_ts),
		.r1_sof   (r1_sof),
		.r1_addr  (r1_base),
		.r1_idx   (r1_idx),
		.r1_ts    (r1_ts)
	);

	////////////////////
	// Address generators

	frame_addr_gen u_wr_gen (
		.clk    (clk),
		.resetn (resetn),
		.sof    (w_sof),
		.beat   (w_beat),
		.base   (w_base),
		.addr   (w_addr),
		.eol    (w_eol),
		.eof    (w_eof)
	);

	frame_addr_gen u_r0_gen (
		.clk    (clk),
		.resetn (resetn),
		.sof    (r0_sof),
		.beat   (r0_beat),
		.base   (r0_base),
		.addr   (r0_addr),
		.eol    (r0_eol),
		.eof    (r0_eof)
	);

	frame_addr_gen u_r1_gen (
		.clk    (clk),
		.resetn (resetn),
		.sof    (r1_sof),
		.beat   (r1_beat),
		.base   (r1_base),
		.addr   (r1_addr),
		.eol    (r1_eol),
		.eof    (r1_eof)
	);

endmodule

//--- tb/fb_ref_model.svh
`ifndef FB_REF_MODEL_SVH
`define FB_REF_MODEL_SVH

// Port 0 is the writer, ports 1 and 2 are the readers
fb_addr_t m_tbl  [FB_BUF_NUM];
fb_idx_t  m_idx  [3];
fb_addr_t m_base [3];
fb_ts_t   m_ts   [1:2];
fb_idx_t  l_idx;
fb_addr_t l_base;
fb_ts_t   l_ts;

// Walk state, g_n counts pixels from the frame start
logic     g_sof_d [3];
logic     g_act   [3];
logic     g_eol   [3];
logic     g_eof   [3];
fb_addr_t g_base  [3];
int       g_n     [3];

int checks = 0;
int errors = 0;

task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
	checks++;
	if (exp !== act) begin
		errors++;
		$display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
	end
endtask

function automatic fb_addr_t exp_addr(input int p);
	return g_base[p]
		+ fb_addr_t'((g_n[p] / FRAME_WIDTH) * LINE_STRIDE)
		+ fb_addr_t'((g_n[p] % FRAME_WIDTH) * BYTES_PER_PIXEL);
endfunction

task automatic model_reset();
	for (int i = 0; i < FB_BUF_NUM; i++) begin
		m_tbl[i] = '0;
	end
	for (int p = 0; p < 3; p++) begin
		m_idx[p]   = '0;
		m_base[p]  = '0;
		g_sof_d[p] = 1'b0;
		g_act[p]   = 1'b0;
		g_eol[p]   = 1'b0;
		g_eof[p]   = 1'b0;
		g_base[p]  = '0;
		g_n[p]     = 0;
	end
	m_idx[0] = fb_idx_t'(1);
	m_ts[1]  = '0;
	m_ts[2]  = '0;
	l_idx    = '0;
	l_base   = '0;
	l_ts     = '0;
endtask

// One clock edge, everything computed from the state before it
task automatic model_step();
	fb_idx_t free_idx;

	// Walkers capture the arbiter base from before this edge
	for (int p = 0; p < 3; p++) begin
		g_eol[p] = 1'b0;
		g_eof[p] = 1'b0;
		if (g_sof_d[p]) begin
			g_base[p] = m_base[p];
			g_n[p]    = 0;
			g_act[p]  = !sof_i[p];
		end else if (sof_i[p]) begin
			g_act[p] = 1'b0;
		end else if (g_act[p] && beat_i[p]) begin
			g_eol[p] = (g_n[p] % FRAME_WIDTH) == FRAME_WIDTH - 1;
			if (g_n[p] == FRAME_PIXELS - 1) begin
				g_eof[p] = 1'b1;
				g_act[p] = 1'b0;
				g_n[p]   = 0;
			end else begin
				g_n[p]++;
			end
		end
		g_sof_d[p] = sof_i[p];
	end

	free_idx = '0;
	for (int i = FB_BUF_NUM - 1; i >= 0; i--) begin
		if (i != m_idx[0] && i != m_idx[1] && i != m_idx[2]) begin
			free_idx = fb_idx_t'(i);
		end
	end

	for (int r = 1; r < 3; r++) begin
		if (sof_i[r] && sof_i[0]) begin
			m_idx[r]  = m_idx[0];
			m_base[r] = m_base[0];
			m_ts[r]   = sys_ts;
		end else if (sof_i[r]) begin
			m_idx[r]  = l_idx;
			m_base[r] = l_base;
			m_ts[r]   = l_ts;
		end
	end

	if (sof_i[0]) begin
		l_idx     = m_idx[0];
		l_base    = m_base[0];
		l_ts      = sys_ts;
		m_idx[0]  = free_idx;
		m_base[0] = m_tbl[free_idx];
	end

	if (cfg_we) begin
		m_tbl[cfg_idx] = cfg_addr;
	end
endtask

`endif

//--- tb/tb_frame_buffer_ctl.sv
module tb_frame_buffer_ctl
	import fb_pkg::*;
	import video_pkg::*;
();

	logic     clk;
	logic     resetn;
	logic     cfg_we;
	fb_idx_t  cfg_idx;
	fb_addr_t cfg_addr;
	fb_ts_t   sys_ts;

	// Index 0 writer, 1 and 2 readers
	logic     sof_i  [3];
	logic     beat_i [3];
	fb_addr_t addr_o [3];
	fb_idx_t  idx_o  [3];
	logic     eol_o  [3];
	logic     eof_o  [3];
	fb_ts_t   ts_o   [1:2];

	int       timeouts = 0;
	int       eol_cnt;
	int       eof_cnt;
	int       wait_cnt;
	fb_idx_t  exp_idx;
	fb_ts_t   exp_ts;
	fb_addr_t hold_addr;

	`include "fb_ref_model.svh"

	frame_buffer_ctl dut (
		.clk      (clk),
		.resetn   (resetn),
		.cfg_we   (cfg_we),
		.cfg_idx  (cfg_idx),
		.cfg_addr (cfg_addr),
		.sys_ts   (sys_ts),
		.w_sof    (sof_i[0]),
		.w_beat   (beat_i[0]),
		.w_addr   (addr_o[0]),
		.w_idx    (idx_o[0]),
		.w_eol    (eol_o[0]),
		.w_eof    (eof_o[0]),
		.r0_sof   (sof_i[1]),
		.r0_beat  (beat_i[1]),
		.r0_addr  (addr_o[1]),
		.r0_idx   (idx_o[1]),
		.r0_ts    (ts_o[1]),
		.r0_eol   (eol_o[1]),
		.r0_eof   (eof_o[1]),
		.r1_sof   (sof_i[2]),
		.r1_beat  (beat_i[2]),
		.r1_addr  (addr_o[2]),
		.r1_idx   (idx_o[2]),
		.r1_ts    (ts_o[2]),
		.r1_eol   (eol_o[2]),
		.r1_eof   (eof_o[2])
	);

	always #50 clk = ~clk;

	////////////////////
	// Helpers

	task automatic compare_all(input string name);
		for (int p = 0; p < 3; p++) begin
			check_val($sformatf("%s idx%0d", name, p), m_idx[p], idx_o[p]);
			check_val($sformatf("%s addr%0d", name, p), exp_addr(p), addr_o[p]);
			check_val($sformatf("%s eol%0d", name, p), g_eol[p], eol_o[p]);
			check_val($sformatf("%s eof%0d", name, p), g_eof[p], eof_o[p]);
		end
		check_val({name, " ts1"}, m_ts[1], ts_o[1]);
		check_val({name, " ts2"}, m_ts[2], ts_o[2]);
		check_val({name, " w_r0_apart"}, 1, idx_o[0] != idx_o[1]);
		check_val({name, " w_r1_apart"}, 1, idx_o[0] != idx_o[2]);
	endtask

	// Inputs change just after the edge
	task automatic tick(input string name);
		@(posedge clk);
		model_step();
		#1;
		compare_all(name);
	endtask

	task automatic drive_idle();
		cfg_we = 1'b0;
		for (int p = 0; p < 3; p++) begin
			sof_i[p]  = 1'b0;
			beat_i[p] = 1'b0;
		end
	endtask

	////////////////////
	// Sequence

	initial begin
		void'($urandom(32'hff88));
		clk      = 1'b0;
		resetn   = 1'b0;
		cfg_idx  = '0;
		cfg_addr = '0;
		sys_ts   = '0;
		drive_idle();
		model_reset();
		repeat (5) @(posedge clk);
		#1;
		resetn = 1'b1;
		compare_all("reset");

		// Base addresses, then one frame start per port
		for (int i = 0; i < FB_BUF_NUM; i++) begin
			cfg_we   = 1'b1;
			cfg_idx  = fb_idx_t'(i);
			cfg_addr = $urandom & 32'hffff_fc00;
			tick("cfg_write");
		end
		drive_idle();

		// One writer frame first, so the last frame carries a table base
		sof_i[0] = 1'b1;
		tick("table_w_sof");
		sof_i[0] = 1'b0;
		tick("table_w_capture");
		check_val("table_addr_first", m_tbl[m_idx[0]], addr_o[0]);

		for (int p = 0; p < 3; p++) begin
			sof_i[p] = 1'b1;
			tick("table_sof");
			sof_i[p] = 1'b0;
			tick("table_capture");
			check_val($sformatf("table_addr%0d", p), m_tbl[m_idx[p]], addr_o[p]);
		end

		// Random frame starts and beats
		for (int c = 0; c < 800; c++) begin
			sys_ts = sys_ts + fb_ts_t'($urandom_range(1, 9));
			for (int p = 0; p < 3; p++) begin
				sof_i[p]  = $urandom_range(0, 15) == 0;
				beat_i[p] = $urandom_range(0, 1);
			end
			cfg_we   = $urandom_range(0, 63) == 0;
			cfg_idx  = fb_idx_t'($urandom);
			cfg_addr = $urandom & 32'hffff_fc00;
			tick("random");
		end
		drive_idle();

		// Reader gets the last finished frame and its time
		exp_idx  = m_idx[0];
		exp_ts   = 64'h0123_4567_89ab_cdef;
		sys_ts   = exp_ts;
		sof_i[0] = 1'b1;
		tick("last_w_sof");
		sof_i[0] = 1'b0;
		sys_ts   = sys_ts + 5;
		repeat (3) tick("last_gap");
		sof_i[1] = 1'b1;
		tick("last_r0_sof");
		sof_i[1] = 1'b0;
		check_val("last_r0_idx", exp_idx, idx_o[1]);
		check_val("last_r0_ts", exp_ts, ts_o[1]);

		exp_idx  = m_idx[0];
		exp_ts   = sys_ts + 100;
		sys_ts   = exp_ts;
		sof_i[0] = 1'b1;
		sof_i[2] = 1'b1;
		tick("same_sof");
		drive_idle();
		check_val("same_r1_idx", exp_idx, idx_o[2]);
		check_val("same_r1_ts", exp_ts, ts_o[2]);

		// Writer walk over one full frame
		sof_i[0] = 1'b1;
		tick("walk_sof");
		sof_i[0] = 1'b0;
		tick("walk_capture");
		check_val("walk_base", m_tbl[m_idx[0]], addr_o[0]);
		eol_cnt  = 0;
		eof_cnt  = 0;
		wait_cnt = 0;
		while (!eof_o[0] && wait_cnt < 4 * FRAME_PIXELS) begin
			beat_i[0] = $urandom_range(0, 1);
			tick("walk");
			eol_cnt += eol_o[0];
			eof_cnt += eof_o[0];
			wait_cnt++;
		end
		if (!eof_o[0]) begin
			$display("Timeout waiting for the writer end of frame");
			timeouts++;
		end
		check_val("walk_eol_count", FRAME_HEIGHT, eol_cnt);
		check_val("walk_eof_count", 1, eof_cnt);

		// Beats after end of frame do nothing
		hold_addr = addr_o[0];
		beat_i[0] = 1'b1;
		repeat (16) tick("walk_idle");
		check_val("walk_idle_addr", hold_addr, addr_o[0]);
		drive_idle();

		$display("Checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+tb
src/fb_pkg.sv
src/video_pkg.sv
src/buffer_addr_table.sv
src/mutex_buffer.sv
src/frame_addr_gen.sv
src/frame_buffer_ctl.sv
tb/tb_frame_buffer_ctl.sv
